// File: common/alpha_pkg.sv
package alpha_pkg;

	// ------------------------------------------------------------
	// widths of the readout path
	// ------------------------------------------------------------
	localparam int WORD_WIDTH = 16; // bits per frame word
	localparam int NYBBLE_WIDTH = 4; // pmod data lines
	localparam int NYBBLES_PER_WORD = WORD_WIDTH / NYBBLE_WIDTH; // four

	// upper byte of the header word, opens every frame
	localparam logic [7:0] HEADER_MARKER = 8'ha5;

	// ------------------------------------------------------------
	// fifo entry
	// ------------------------------------------------------------
	// top bit is the msn flag, the rest is the nybble itself
	typedef logic [NYBBLE_WIDTH:0] nybble_entry_t;

	// ------------------------------------------------------------
	// frame word, msb arrives first on the serial line
	// ------------------------------------------------------------
	typedef union packed {
		// header view
		struct packed {
			logic [7:0] marker; // must equal HEADER_MARKER
			logic [7:0] sample_count; // 0 means 256
		} header;
		// sample view
		struct packed {
			logic [3:0] channel; // goes out first, with msn set
			logic [11:0] adc_value; // then top, middle, bottom nybble
		} sample;
	} alpha_word_t;

endpackage

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_alpha_pmod_readout \
	-f verilog.f \
	-o tb_alpha_pmod_readout

output=$(./obj_dir/tb_alpha_pmod_readout)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
exit 1

// File: testbench/tb_alpha_pmod_readout.sv
module tb_alpha_pmod_readout;
	timeunit 1ns;
	timeprecision 1ps;
	import alpha_pkg::*;

	localparam logic [1:0] RX_IDLE = 2'd0; // waiting for a strobe
	localparam logic [1:0] RX_DELAY = 2'd1; // counting down to the ack
	localparam logic [1:0] RX_ACKED = 2'd2; // ack high, waiting for strobe low
	localparam int DRAIN_TIMEOUT = 4000; // cycles
	localparam int QUIET_CYCLES = 200;

	logic clock;
	logic reset;
	logic input_bit;
	logic bit_valid;
	logic acknowledge;
	logic [NYBBLE_WIDTH-1:0] pmod_nybble;
	logic pmod_msn;
	logic pmod_strobe;
	logic overflow;

	logic stream_q[$]; // serial bits still to send
	logic [NYBBLE_WIDTH:0] expected_q[$]; // {msn, nybble}, oldest first
	logic [7:0] recent_bits; // last eight bits queued
	logic hold_ack; // receiver stalls while set
	logic [1:0] rx_state;
	logic timed_out;
	int error_count;
	int check_count;
	int received_count;
	int tests_run;
	int tests_failed;

	alpha_pmod_readout i_alpha_pmod_readout (
		.clock(clock),
		.reset(reset),
		.input_bit(input_bit),
		.bit_valid(bit_valid),
		.acknowledge(acknowledge),
		.pmod_nybble(pmod_nybble),
		.pmod_msn(pmod_msn),
		.pmod_strobe(pmod_strobe),
		.overflow(overflow)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock; // 8 ns period
	end

	// ------------------------------------------------------------
	// stimulus building
	// ------------------------------------------------------------
	// a noise bit that would complete the marker byte gets flipped
	task automatic queue_bit(input logic value, input bit is_noise);
		logic b;
		b = value;
		if (is_noise && ({recent_bits[6:0], b} == HEADER_MARKER)) begin
			b = ~b;
		end
		recent_bits = {recent_bits[6:0], b};
		stream_q.push_back(b);
	endtask

	task automatic queue_word(input logic [WORD_WIDTH-1:0] value);
		for (int i = WORD_WIDTH - 1; i >= 0; i--) begin
			queue_bit(value[i], 1'b0); // msb first
		end
	endtask

	// random bits, closed by a zero byte so no marker can start early
	task automatic queue_noise(input int length);
		for (int i = 0; i < length; i++) begin
			queue_bit(1'($urandom_range(1, 0)), 1'b1);
		end
		for (int i = 0; i < 8; i++) begin
			queue_bit(1'b0, 1'b0);
		end
	endtask

	// header then samples, each sample expected as four nybbles from the top
	task automatic queue_frame(input logic [7:0] count_field, input int samples);
		logic [WORD_WIDTH-1:0] sample;
		queue_word({HEADER_MARKER, count_field});
		for (int s = 0; s < samples; s++) begin
			sample = WORD_WIDTH'($urandom);
			queue_word(sample);
			for (int k = 0; k < NYBBLES_PER_WORD; k++) begin
				expected_q.push_back({(k == 0),
					sample[WORD_WIDTH - 1 - NYBBLE_WIDTH * k -: NYBBLE_WIDTH]});
			end
		end
	endtask

	// at least three quiet cycles between accepted bits
	task automatic drive_stream();
		logic b;
		int gap;
		while (stream_q.size() > 0) begin
			b = stream_q.pop_front();
			gap = 3 + int'($urandom_range(4, 0));
			repeat (gap) begin
				@(posedge clock);
				#1;
				bit_valid = 1'b0;
			end
			@(posedge clock);
			#1;
			input_bit = b;
			bit_valid = 1'b1;
		end
		@(posedge clock);
		#1;
		bit_valid = 1'b0;
	endtask

	// ------------------------------------------------------------
	// checks and waits
	// ------------------------------------------------------------
	task automatic check_value(input string what, input int actual, input int expected);
		check_count++;
		assert (actual == expected) else begin
			$display("FAIL %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			error_count++;
		end
	endtask

	task automatic check_nybble(input logic [NYBBLE_WIDTH:0] seen);
		logic [NYBBLE_WIDTH:0] expected;
		check_count++;
		received_count++;
		assert (expected_q.size() > 0) else begin
			$display("FAIL %0t: nybble %h msn %b arrived with none expected",
				$time, seen[3:0], seen[4]);
			error_count++;
		end
		if (expected_q.size() > 0) begin
			expected = expected_q.pop_front();
			assert (seen === expected) else begin
				$display("FAIL %0t: nybble %h msn %b, expected %h msn %b",
					$time, seen[3:0], seen[4], expected[3:0], expected[4]);
				error_count++;
			end
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while ((expected_q.size() > 0 || rx_state != RX_IDLE) && cycles < DRAIN_TIMEOUT) begin
			@(posedge clock);
			#2; // after the receiver has moved
			cycles++;
		end
		if (expected_q.size() > 0 || rx_state != RX_IDLE) begin
			$display("timeout: %0d nybbles never reached the receiver", expected_q.size());
			timed_out = 1'b1;
		end
	endtask

	task automatic idle_cycles(input int count);
		repeat (count) @(posedge clock);
		#2;
	endtask

	task automatic send_and_collect();
		drive_stream();
		wait_drained();
		idle_cycles(QUIET_CYCLES); // nothing extra may follow
	endtask

	task automatic apply_reset();
		@(posedge clock);
		#1;
		reset = 1'b1;
		bit_valid = 1'b0;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		recent_bits = '0; // aligner starts from a clean register
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (error_count > errors_before || timed_out) begin
			tests_failed++;
			$display("test %0d %s: failed", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
	endtask

	// ------------------------------------------------------------
	// receiver model
	// ------------------------------------------------------------
	initial begin : receiver
		int delay;
		acknowledge = 1'b0;
		rx_state = RX_IDLE;
		delay = 0;
		forever begin
			@(posedge clock);
			#1;
			if (reset) begin
				acknowledge = 1'b0;
				rx_state = RX_IDLE;
			end else begin
				case (rx_state)
					RX_IDLE: if (pmod_strobe && !hold_ack) begin
						check_nybble({pmod_msn, pmod_nybble}); // data valid with strobe
						delay = int'($urandom_range(3, 0));
						if (delay == 0) begin
							acknowledge = 1'b1;
							rx_state = RX_ACKED;
						end else begin
							rx_state = RX_DELAY;
						end
					end
					RX_DELAY: begin
						delay--;
						if (delay == 0) begin
							acknowledge = 1'b1;
							rx_state = RX_ACKED;
						end
					end
					RX_ACKED: if (!pmod_strobe) begin
						acknowledge = 1'b0; // release once the strobe is gone
						rx_state = RX_IDLE;
					end
					default: rx_state = RX_IDLE;
				endcase
			end
		end
	end

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		int mark;
		int count;
		int total;
		void'($urandom(32'h6d19));
		reset = 1'b1;
		input_bit = 1'b0;
		bit_valid = 1'b0;
		hold_ack = 1'b0;
		recent_bits = '0;
		timed_out = 1'b0;
		error_count = 0;
		check_count = 0;
		received_count = 0;
		tests_run = 0;
		tests_failed = 0;
		apply_reset();

		mark = error_count;
		check_value("pmod_strobe after reset", pmod_strobe, 0);
		check_value("overflow after reset", overflow, 0);
		for (int i = 0; i < 40; i++) begin
			queue_bit(1'b0, 1'b0); // line idles low
		end
		drive_stream();
		idle_cycles(QUIET_CYCLES);
		check_value("nybbles from idle bits", received_count, 0);
		finish_test("idle after reset", mark);

		mark = error_count;
		received_count = 0;
		queue_frame(8'd3, 3);
		send_and_collect();
		check_value("nybbles of a three sample frame", received_count, 12);
		finish_test("three sample frame", mark);

		mark = error_count;
		received_count = 0;
		queue_noise(60);
		queue_frame(8'd2, 2);
		queue_noise(40); // tail after the last sample
		send_and_collect();
		check_value("nybbles around noise", received_count, 8);
		finish_test("noise before and after a frame", mark);

		mark = error_count;
		received_count = 0;
		total = 256;
		queue_frame(8'd0, 256); // count 0 stands for 256
		for (int f = 0; f < 3; f++) begin
			count = 1 + int'($urandom_range(15, 0));
			queue_frame(8'(count), count);
			total += count;
		end
		send_and_collect();
		check_value("nybbles of back-to-back frames", received_count, 4 * total);
		check_value("overflow after back-to-back frames", overflow, 0);
		finish_test("full count and back-to-back frames", mark);

		mark = error_count;
		received_count = 0;
		hold_ack = 1'b1;
		queue_frame(8'd12, 12);
		while (expected_q.size() > 32) begin
			void'(expected_q.pop_back()); // fifo keeps only the first 32
		end
		drive_stream();
		idle_cycles(8); // splitter finishes its last writes
		check_value("overflow under back-pressure", overflow, 1);
		check_value("pmod_strobe held under back-pressure", pmod_strobe, 1);
		hold_ack = 1'b0;
		send_and_collect();
		check_value("nybbles after back-pressure", received_count, 32);
		check_value("overflow after draining", overflow, 1);
		apply_reset();
		check_value("overflow after a new reset", overflow, 0);
		check_value("pmod_strobe after a new reset", pmod_strobe, 0);
		finish_test("back-pressure and overflow", mark);

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, check_count, error_count);
		if (error_count == 0 && tests_failed == 0 && !timed_out) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
common/alpha_pkg.sv
verilog/readout/word_aligner.sv
verilog/readout/nybble_splitter.sv
verilog/nybble_fifo.sv
verilog/pmod_handshake.sv
verilog/alpha_pmod_readout.sv
testbench/tb_alpha_pmod_readout.sv

// File: verilog/alpha_pmod_readout.sv
module alpha_pmod_readout #(
	parameter int FIFO_DEPTH_LOG2 = 5 // 32 nybbles
) (
	input logic clock,
	input logic reset,
	input logic input_bit,
	input logic bit_valid,
	input logic acknowledge,
	output logic [alpha_pkg::NYBBLE_WIDTH-1:0] pmod_nybble,
	output logic pmod_msn,
	output logic pmod_strobe,
	output logic overflow
);
	import alpha_pkg::*;

	logic word_valid;
	alpha_word_t word;
	logic write_enable;
	nybble_entry_t write_entry;
	logic full;
	nybble_entry_t read_entry;
	logic empty;
	logic read_enable;

	// ------------------------------------------------------------
	// input side
	// ------------------------------------------------------------
	word_aligner i_word_aligner (
		.clock(clock),
		.reset(reset),
		.input_bit(input_bit),
		.bit_valid(bit_valid),
		.word_valid(word_valid),
		.word(word)
	);

	// ------------------------------------------------------------
	// processing
	// ------------------------------------------------------------
	nybble_splitter i_nybble_splitter (
		.clock(clock),
		.reset(reset),
		.word_valid(word_valid),
		.word(word),
		.full(full),
		.write_enable(write_enable),
		.write_entry(write_entry),
		.overflow(overflow)
	);

	nybble_fifo #(
		.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
	) i_nybble_fifo (
		.clock(clock),
		.reset(reset),
		.write_enable(write_enable),
		.write_entry(write_entry),
		.full(full),
		.read_enable(read_enable),
		.read_entry(read_entry),
		.empty(empty)
	);

	// output side, towards the pmod receiver
	pmod_handshake i_pmod_handshake (
		.clock(clock),
		.reset(reset),
		.read_entry(read_entry),
		.empty(empty),
		.read_enable(read_enable),
		.acknowledge(acknowledge),
		.pmod_nybble(pmod_nybble),
		.pmod_msn(pmod_msn),
		.pmod_strobe(pmod_strobe)
	);

endmodule

// File: verilog/nybble_fifo.sv
module nybble_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 5
) (
	input logic clock,
	input logic reset,
	input logic write_enable,
	input alpha_pkg::nybble_entry_t write_entry,
	output logic full,
	input logic read_enable, // pops the head
	output alpha_pkg::nybble_entry_t read_entry, // valid whenever not empty
	output logic empty
);
	import alpha_pkg::*;

	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

	nybble_entry_t memory [DEPTH]; // no reset
	logic [FIFO_DEPTH_LOG2-1:0] write_pointer;
	logic [FIFO_DEPTH_LOG2-1:0] read_pointer;
	logic [FIFO_DEPTH_LOG2:0] occupancy; // one extra bit to tell full from empty

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (write_enable) begin
			memory[write_pointer] <= write_entry;
		end
	end

	assign read_entry = memory[read_pointer]; // fall-through head

	// ------------------------------------------------------------
	// pointers and occupancy
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			write_pointer <= '0;
			read_pointer <= '0;
			occupancy <= '0;
		end else begin
			if (write_enable) begin
				write_pointer <= write_pointer + 1'b1; // wraps at DEPTH
			end
			if (read_enable) begin
				read_pointer <= read_pointer + 1'b1;
			end
			case ({write_enable, read_enable})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy; // none, or both at once
			endcase
		end
	end

	assign full = occupancy[FIFO_DEPTH_LOG2]; // only set at exactly DEPTH
	assign empty = (occupancy == '0);

	// ------------------------------------------------------------
	// neighbours must respect the flags
	// ------------------------------------------------------------
	a_no_write_when_full : assert property (
		@(posedge clock) disable iff (reset)
		full |-> !write_enable
	) else $error("fifo written while full");

	a_no_read_when_empty : assert property (
		@(posedge clock) disable iff (reset)
		empty |-> !read_enable
	) else $error("fifo read while empty");

endmodule

// File: verilog/pmod_handshake.sv
module pmod_handshake (
	input logic clock,
	input logic reset,
	input alpha_pkg::nybble_entry_t read_entry,
	input logic empty,
	output logic read_enable,
	input logic acknowledge, // from the receiver, asynchronous
	output logic [alpha_pkg::NYBBLE_WIDTH-1:0] pmod_nybble,
	output logic pmod_msn,
	output logic pmod_strobe
);
	import alpha_pkg::*;

	localparam logic [1:0] IDLE = 2'd0; // waiting for the fifo
	localparam logic [1:0] STROBING = 2'd1; // data out, strobe high
	localparam logic [1:0] RELEASING = 2'd2; // waiting for ack to drop

	logic [1:0] state;
	logic ack_meta; // first synchronizer stage
	logic ack_sync;
	logic load;

	// ------------------------------------------------------------
	// acknowledge synchronizer
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			ack_meta <= 1'b0;
			ack_sync <= 1'b0;
		end else begin
			ack_meta <= acknowledge;
			ack_sync <= ack_meta;
		end
	end

	assign load = (state == IDLE) && !empty;
	assign read_enable = (state == STROBING) && ack_sync; // pop as strobe drops

	// head entry stays in the fifo until acknowledged
	always_ff @(posedge clock) begin
		if (load) begin
			pmod_nybble <= read_entry[NYBBLE_WIDTH-1:0];
			pmod_msn <= read_entry[NYBBLE_WIDTH];
		end
	end

	// ------------------------------------------------------------
	// four-phase sender
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
			pmod_strobe <= 1'b0;
		end else begin
			case (state)
				IDLE: if (load) begin
					pmod_strobe <= 1'b1; // data goes out with the strobe
					state <= STROBING;
				end
				STROBING: if (ack_sync) begin
					pmod_strobe <= 1'b0;
					state <= RELEASING;
				end
				RELEASING: if (!ack_sync) begin
					state <= IDLE; // receiver let go
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_data_stable : assert property (
		@(posedge clock) disable iff (reset)
		pmod_strobe && $past(pmod_strobe) |-> $stable(pmod_nybble) && $stable(pmod_msn)
	) else $error("pmod data changed while strobe high");

endmodule

// File: verilog/readout/nybble_splitter.sv
module nybble_splitter (
	input logic clock,
	input logic reset,
	input logic word_valid,
	input alpha_pkg::alpha_word_t word,
	input logic full, // from the fifo
	output logic write_enable,
	output alpha_pkg::nybble_entry_t write_entry,
	output logic overflow // sticky, cleared by reset only
);
	import alpha_pkg::*;

	localparam int INDEX_WIDTH = $clog2(NYBBLES_PER_WORD);
	localparam logic [INDEX_WIDTH-1:0] LAST_INDEX = INDEX_WIDTH'(NYBBLES_PER_WORD - 1);

	alpha_word_t held_word; // payload, no reset
	logic [INDEX_WIDTH-1:0] index; // which nybble goes out next
	logic busy; // four write cycles in progress
	logic [NYBBLE_WIDTH-1:0] nybble;

	// channel first, then adc_value top to bottom
	always_comb begin
		case (index)
			2'd0: nybble = held_word.sample.channel;
			2'd1: nybble = held_word.sample.adc_value[11:8];
			2'd2: nybble = held_word.sample.adc_value[7:4];
			default: nybble = held_word.sample.adc_value[3:0];
		endcase
	end

	assign write_entry = {(index == '0), nybble}; // msn only on the channel
	assign write_enable = busy && !full; // dropped when full

	always_ff @(posedge clock) begin
		if (word_valid) begin
			held_word <= word;
		end
	end

	// ------------------------------------------------------------
	// index and overflow
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			busy <= 1'b0;
			index <= '0;
			overflow <= 1'b0;
		end else begin
			if (word_valid) begin
				busy <= 1'b1;
				index <= '0;
			end else if (busy) begin
				index <= index + 1'b1;
				if (index == LAST_INDEX) begin
					busy <= 1'b0;
				end
			end
			if (busy && full) begin
				overflow <= 1'b1; // a nybble was lost
			end
		end
	end

	// aligner needs 16 accepted bits per word, so it never catches up
	a_no_overrun : assert property (
		@(posedge clock) disable iff (reset)
		word_valid |-> !busy
	) else $error("new word arrived while still splitting the last one");

endmodule

// File: verilog/readout/word_aligner.sv
module word_aligner (
	input logic clock,
	input logic reset,
	input logic input_bit, // serial data, msb first
	input logic bit_valid, // qualifies input_bit
	output logic word_valid, // one cycle per sample word
	output alpha_pkg::alpha_word_t word
);
	import alpha_pkg::*;

	localparam int BIT_COUNT_WIDTH = $clog2(WORD_WIDTH);
	localparam logic [BIT_COUNT_WIDTH-1:0] LAST_BIT = BIT_COUNT_WIDTH'(WORD_WIDTH - 1);
	localparam int SAMPLES_WIDTH = 9; // enough for 256

	alpha_word_t next_word; // shift register after the current bit
	logic hunting; // looking for the header marker
	logic [BIT_COUNT_WIDTH-1:0] bit_count;
	logic [SAMPLES_WIDTH-1:0] samples_left;
	logic marker_seen;
	logic [SAMPLES_WIDTH-1:0] frame_samples;

	// ------------------------------------------------------------
	// shift and compare
	// ------------------------------------------------------------
	always_comb begin
		next_word = {word[WORD_WIDTH-2:0], input_bit}; // msb first
	end

	// only compare once the register holds 16 fresh bits
	// so the tail of the last sample can never fake a header
	assign marker_seen = hunting && (bit_count == LAST_BIT)
		&& (next_word.header.marker == HEADER_MARKER);

	// sample count of 0 stands for a full 256
	always_comb begin
		if (next_word.header.sample_count == 8'd0) begin
			frame_samples = 9'd256;
		end else begin
			frame_samples = {1'b0, next_word.header.sample_count};
		end
	end

	// ------------------------------------------------------------
	// hunt / sample counter
	// ------------------------------------------------------------
	always_ff @(posedge clock) begin
		word_valid <= 1'b0; // pulse only
		if (reset) begin
			word <= '0;
			hunting <= 1'b1;
			bit_count <= '0;
			samples_left <= '0;
		end else if (bit_valid) begin
			word <= next_word; // also holds the sample for the splitter
			if (hunting) begin
				if (marker_seen) begin
					hunting <= 1'b0; // header consumed here
					bit_count <= '0;
					samples_left <= frame_samples;
				end else if (bit_count != LAST_BIT) begin
					bit_count <= bit_count + 1'b1; // saturates while filling
				end
			end else begin
				bit_count <= bit_count + 1'b1; // wraps to 0 after bit 15
				if (bit_count == LAST_BIT) begin
					word_valid <= 1'b1;
					samples_left <= samples_left - 1'b1;
					if (samples_left == 9'd1) begin
						hunting <= 1'b1; // last sample of the frame
					end
				end
			end
		end
	end

	// ------------------------------------------------------------
	// checks
	// ------------------------------------------------------------
	// the splitter needs four quiet cycles, back-to-back words would break it
	a_word_valid_single : assert property (
		@(posedge clock) disable iff (reset)
		word_valid |=> !word_valid
	) else $error("word_valid high on two consecutive cycles");

endmodule
